/* verilog/reuleaux_pkg.sv */
package reuleaux_pkg;

    // screen coordinates as the plot port sees them
    typedef logic [7:0] coord_x_t;
    typedef logic [6:0] coord_y_t;

    // 3-bit pixel colour, 0 is black
    typedef logic [2:0] colour_t;

    // side length of the triangle, always even
    typedef logic [7:0] diam_t;

    // signed working coordinate
    // arc points around far vertices can land well off the screen
    typedef logic signed [9:0] span_t;

    // top vertex sits diameter * 591 / 1024 above the centre
    localparam logic [9:0] top_num = 10'd591;

    // base vertices sit diameter * 296 / 1024 below the centre
    localparam logic [9:0] bot_num = 10'd296;

    // draw controller
    typedef enum logic [1:0] {
        idle,
        clearing,
        tracing,
        finished
    } ctrl_state_t;

    // arc tracer
    typedef enum logic [1:0] {
        t_idle,
        t_setup,
        t_step,
        t_next_arc
    } trace_state_t;

endpackage

/* verilog/pixel_if.sv */
interface pixel_if import reuleaux_pkg::*; ();

    // candidate pixel, signed so it may still be off the screen
    span_t   x;
    span_t   y;
    colour_t colour;

    // pixel present this cycle
    logic    valid;

    // final item of the stream, may come with valid low
    logic    last;

    modport source (
        output x,
        output y,
        output colour,
        output valid,
        output last
    );

    modport sink (
        input x,
        input y,
        input colour,
        input valid,
        input last
    );

endinterface

/* verilog/screen_clear.sv */
module screen_clear import reuleaux_pkg::*; #(
    parameter int screen_w = 160,
    parameter int screen_h = 120
) (
    input  logic     vif,
    input  logic     reset,
    input  logic     go,
    output coord_x_t x,
    output coord_y_t y,
    output logic     valid,
    output logic     last
);

    coord_x_t col;
    coord_y_t row;
    logic     active;
    logic     col_end;
    logic     row_end;

    assign col_end = (col == coord_x_t'(screen_w - 1));
    assign row_end = (row == coord_y_t'(screen_h - 1));

    // x is the outer loop, y the inner one
    always_ff @(posedge vif) begin
        if (reset) begin
            active <= 1'b0;
            col    <= '0;
            row    <= '0;
        end else if (go) begin
            active <= 1'b1;
            col    <= '0;
            row    <= '0;
        end else if (active) begin
            if (row_end) begin
                row <= '0;
                col <= col + 1'b1;
                // bottom right corner closes the sweep
                if (col_end) begin
                    active <= 1'b0;
                end
            end else begin
                row <= row + 1'b1;
            end
        end
    end

    assign x     = col;
    assign y     = row;
    assign valid = active;
    assign last  = active && col_end && row_end;

endmodule

/* verilog/arc_tracer.sv */
module arc_tracer import reuleaux_pkg::*; (
    input  logic    vif,
    input  logic    reset,
    input  logic    go,
    input  coord_x_t cmd_cx,
    input  coord_y_t cmd_cy,
    input  diam_t   cmd_d,
    input  colour_t cmd_colour,
    pixel_if.source trace_px
);

    trace_state_t      state;
    logic [1:0]        arc;
    logic [2:0]        oct;

    // current vertex and midpoint circle state
    span_t             vx;
    span_t             vy;
    span_t             ox;
    span_t             oy;
    logic signed [11:0] crit;

    logic [17:0]       top_prod;
    logic [17:0]       bot_prod;
    span_t             cx_s;
    span_t             cy_s;
    span_t             half_d;
    span_t             radius;
    span_t             top_off;
    span_t             bot_off;
    span_t             vert_x;
    span_t             vert_y;

    span_t             ox_n;
    span_t             oy_n;
    logic signed [11:0] crit_n;
    logic              arc_end;
    span_t             pt_x;
    span_t             pt_y;

    assign top_prod = cmd_d * top_num;
    assign bot_prod = cmd_d * bot_num;
    assign top_off  = span_t'({2'b00, top_prod[17:10]});
    assign bot_off  = span_t'({2'b00, bot_prod[17:10]});
    assign cx_s     = span_t'({2'b00, cmd_cx});
    assign cy_s     = span_t'({3'b000, cmd_cy});
    assign half_d   = span_t'({3'b000, cmd_d[7:1]});
    assign radius   = span_t'({2'b00, cmd_d});

    // arc 0 around the top vertex, then right, then left
    always_comb begin
        case (arc)
            2'd0: begin
                vert_x = cx_s;
                vert_y = cy_s - top_off;
            end
            2'd1: begin
                vert_x = cx_s + half_d;
                vert_y = cy_s + bot_off;
            end
            default: begin
                vert_x = cx_s - half_d;
                vert_y = cy_s + bot_off;
            end
        endcase
    end

    // one midpoint step, taken after the eighth octant point
    always_comb begin
        oy_n = oy + 10'sd1;
        if (crit <= 12'sd0) begin
            ox_n   = ox;
            crit_n = crit + (12'(oy_n) <<< 1) + 12'sd1;
        end else begin
            ox_n   = ox - 10'sd1;
            crit_n = crit + ((12'(oy_n) - 12'(ox_n)) <<< 1) + 12'sd1;
        end
        arc_end = (oy_n > ox_n);
    end

    always_comb begin
        case (oct)
            3'd0: begin pt_x = vx + ox; pt_y = vy + oy; end
            3'd1: begin pt_x = vx + oy; pt_y = vy + ox; end
            3'd2: begin pt_x = vx - oy; pt_y = vy + ox; end
            3'd3: begin pt_x = vx - ox; pt_y = vy + oy; end
            3'd4: begin pt_x = vx - ox; pt_y = vy - oy; end
            3'd5: begin pt_x = vx - oy; pt_y = vy - ox; end
            3'd6: begin pt_x = vx + oy; pt_y = vy - ox; end
            default: begin pt_x = vx + ox; pt_y = vy - oy; end
        endcase
    end

    always_ff @(posedge vif) begin
        if (reset) begin
            state          <= t_idle;
            arc            <= '0;
            oct            <= '0;
            trace_px.valid <= 1'b0;
            trace_px.last  <= 1'b0;
        end else begin
            trace_px.valid <= 1'b0;
            trace_px.last  <= 1'b0;
            case (state)
                t_idle: begin
                    if (go) begin
                        arc   <= '0;
                        state <= t_setup;
                    end
                end
                t_setup: begin
                    oct <= '0;
                    // nothing to draw, close the stream at once
                    if (cmd_d == '0) begin
                        trace_px.last <= 1'b1;
                        state         <= t_idle;
                    end else begin
                        state <= t_step;
                    end
                end
                t_step: begin
                    trace_px.valid <= 1'b1;
                    oct            <= oct + 1'b1;
                    if (oct == 3'd7 && arc_end) begin
                        if (arc == 2'd2) begin
                            trace_px.last <= 1'b1;
                            state         <= t_idle;
                        end else begin
                            state <= t_next_arc;
                        end
                    end
                end
                t_next_arc: begin
                    arc   <= arc + 1'b1;
                    state <= t_setup;
                end
            endcase
        end
    end

    always_ff @(posedge vif) begin
        if (state == t_setup) begin
            vx   <= vert_x;
            vy   <= vert_y;
            ox   <= radius;
            oy   <= '0;
            crit <= 12'sd1 - 12'(radius);
        end else if (state == t_step) begin
            trace_px.x      <= pt_x;
            trace_px.y      <= pt_y;
            trace_px.colour <= cmd_colour;
            if (oct == 3'd7) begin
                ox   <= ox_n;
                oy   <= oy_n;
                crit <= crit_n;
            end
        end
    end

endmodule

/* verilog/arc_clip.sv */
module arc_clip import reuleaux_pkg::*; #(
    parameter int screen_w = 160,
    parameter int screen_h = 120
) (
    input  logic     vif,
    input  logic     reset,
    input  coord_x_t cmd_cx,
    input  coord_y_t cmd_cy,
    input  diam_t    cmd_d,
    pixel_if.sink    trace_px,
    pixel_if.source  clip_px
);

    logic [17:0] bot_prod;
    span_t       cx_s;
    span_t       base_y;
    logic [1:0]  arc;
    logic        prev_valid;
    logic        keep_arc;
    logic        on_screen;

    assign bot_prod = cmd_d * bot_num;
    assign cx_s     = span_t'({2'b00, cmd_cx});
    assign base_y   = span_t'({3'b000, cmd_cy}) + span_t'({2'b00, bot_prod[17:10]});

    // outline segment of each arc
    always_comb begin
        case (arc)
            2'd0: keep_arc = (trace_px.y >= base_y);
            2'd1: keep_arc = (trace_px.x <= cx_s) && (trace_px.y <= base_y);
            2'd2: keep_arc = (trace_px.x >= cx_s) && (trace_px.y <= base_y);
            default: keep_arc = 1'b0;
        endcase
    end

    assign on_screen = (trace_px.x >= 10'sd0) && (trace_px.x <= span_t'(screen_w - 1)) &&
                       (trace_px.y >= 10'sd0) && (trace_px.y <= span_t'(screen_h - 1));

    // the tracer leaves idle cycles between arcs
    // so each falling edge of valid moves on to the next arc
    always_ff @(posedge vif) begin
        if (reset) begin
            arc           <= '0;
            prev_valid    <= 1'b0;
            clip_px.valid <= 1'b0;
            clip_px.last  <= 1'b0;
        end else begin
            clip_px.valid <= trace_px.valid && keep_arc && on_screen;
            clip_px.last  <= trace_px.last;
            if (trace_px.last) begin
                arc        <= '0;
                prev_valid <= 1'b0;
            end else begin
                prev_valid <= trace_px.valid;
                if (prev_valid && !trace_px.valid) begin
                    arc <= arc + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge vif) begin
        clip_px.x      <= trace_px.x;
        clip_px.y      <= trace_px.y;
        clip_px.colour <= trace_px.colour;
    end

endmodule

/* verilog/draw_control.sv */
module draw_control import reuleaux_pkg::*; (
    input  logic     vif,
    input  logic     reset,
    input  logic     start,
    input  coord_x_t centre_x,
    input  coord_y_t centre_y,
    input  diam_t    diameter,
    input  colour_t  colour,
    output logic     done,
    output logic     clear_go,
    output logic     trace_go,
    input  coord_x_t clear_x,
    input  coord_y_t clear_y,
    input  logic     clear_valid,
    input  logic     clear_last,
    pixel_if.sink    clip_px,
    output coord_x_t vga_x,
    output coord_y_t vga_y,
    output colour_t  vga_colour,
    output logic     vga_plot,
    output coord_x_t cmd_cx,
    output coord_y_t cmd_cy,
    output diam_t    cmd_d,
    output colour_t  cmd_colour
);

    ctrl_state_t state;

    always_ff @(posedge vif) begin
        if (reset) begin
            state    <= idle;
            done     <= 1'b0;
            clear_go <= 1'b0;
            trace_go <= 1'b0;
            vga_plot <= 1'b0;
        end else begin
            clear_go <= 1'b0;
            trace_go <= 1'b0;
            vga_plot <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        clear_go <= 1'b1;
                        state    <= clearing;
                    end
                end
                clearing: begin
                    vga_plot <= clear_valid;
                    if (clear_valid && clear_last) begin
                        trace_go <= 1'b1;
                        state    <= tracing;
                    end
                end
                tracing: begin
                    vga_plot <= clip_px.valid;
                    if (clip_px.last) begin
                        state <= finished;
                    end
                end
                finished: begin
                    // done waits one cycle so the last plot is out first
                    if (!done) begin
                        done <= 1'b1;
                    end else if (!start) begin
                        done  <= 1'b0;
                        state <= idle;
                    end
                end
            endcase
        end
    end

    // command is taken in the cycle start is seen
    always_ff @(posedge vif) begin
        if (state == idle && start) begin
            cmd_cx     <= centre_x;
            cmd_cy     <= centre_y;
            cmd_d      <= diameter;
            cmd_colour <= colour;
        end
    end

    always_ff @(posedge vif) begin
        if (state == clearing) begin
            vga_x      <= clear_x;
            vga_y      <= clear_y;
            vga_colour <= '0;
        end else begin
            vga_x      <= coord_x_t'(clip_px.x);
            vga_y      <= coord_y_t'(clip_px.y);
            vga_colour <= clip_px.colour;
        end
    end

endmodule

/* verilog/reuleaux_top.sv */
module reuleaux_top import reuleaux_pkg::*; #(
    parameter int screen_w = 160,
    parameter int screen_h = 120
) (
    input  logic     vif,
    input  logic     reset,
    input  logic     start,
    input  coord_x_t centre_x,
    input  coord_y_t centre_y,
    input  diam_t    diameter,
    input  colour_t  colour,
    output logic     done,
    output coord_x_t vga_x,
    output coord_y_t vga_y,
    output colour_t  vga_colour,
    output logic     vga_plot
);

    logic     clear_go;
    logic     trace_go;
    coord_x_t clear_x;
    coord_y_t clear_y;
    logic     clear_valid;
    logic     clear_last;
    coord_x_t cmd_cx;
    coord_y_t cmd_cy;
    diam_t    cmd_d;
    colour_t  cmd_colour;

    // tracer to clipper, clipper to controller
    pixel_if trace_px ();
    pixel_if clip_px ();

    draw_control u_ctrl (
        .vif         (vif),
        .reset       (reset),
        .start       (start),
        .centre_x    (centre_x),
        .centre_y    (centre_y),
        .diameter    (diameter),
        .colour      (colour),
        .done        (done),
        .clear_go    (clear_go),
        .trace_go    (trace_go),
        .clear_x     (clear_x),
        .clear_y     (clear_y),
        .clear_valid (clear_valid),
        .clear_last  (clear_last),
        .clip_px     (clip_px.sink),
        .vga_x       (vga_x),
        .vga_y       (vga_y),
        .vga_colour  (vga_colour),
        .vga_plot    (vga_plot),
        .cmd_cx      (cmd_cx),
        .cmd_cy      (cmd_cy),
        .cmd_d       (cmd_d),
        .cmd_colour  (cmd_colour)
    );

    screen_clear #(
        .screen_w (screen_w),
        .screen_h (screen_h)
    ) u_clear (
        .vif   (vif),
        .reset (reset),
        .go    (clear_go),
        .x     (clear_x),
        .y     (clear_y),
        .valid (clear_valid),
        .last  (clear_last)
    );

    arc_tracer u_tracer (
        .vif        (vif),
        .reset      (reset),
        .go         (trace_go),
        .cmd_cx     (cmd_cx),
        .cmd_cy     (cmd_cy),
        .cmd_d      (cmd_d),
        .cmd_colour (cmd_colour),
        .trace_px   (trace_px.source)
    );

    arc_clip #(
        .screen_w (screen_w),
        .screen_h (screen_h)
    ) u_clip (
        .vif      (vif),
        .reset    (reset),
        .cmd_cx   (cmd_cx),
        .cmd_cy   (cmd_cy),
        .cmd_d    (cmd_d),
        .trace_px (trace_px.sink),
        .clip_px  (clip_px.source)
    );

endmodule

/* testbench/reuleaux_properties.sv */
module reuleaux_checker import reuleaux_pkg::*; #(
    parameter int screen_w = 160,
    parameter int screen_h = 120
) (
    input logic     vif,
    input logic     reset,
    input logic     start,
    input coord_x_t centre_x,
    input coord_y_t centre_y,
    input diam_t    diameter,
    input colour_t  colour,
    input logic     done,
    input coord_x_t vga_x,
    input coord_y_t vga_y,
    input colour_t  vga_colour,
    input logic     vga_plot
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clear_plots = screen_w * screen_h;

    int       error_count = 0;
    logic     idle_m;
    coord_x_t cx_m;
    coord_y_t cy_m;
    diam_t    d_m;
    colour_t  colour_m;
    int       plot_count;
    coord_x_t exp_x;
    coord_y_t exp_y;
    int       slack;
    int       top_y;
    int       x_lo;
    int       x_hi;
    int       y_hi;

    // expected controller phase, command and raster position
    always_ff @(posedge vif) begin
        if (reset) begin
            idle_m     <= 1'b1;
            plot_count <= 0;
            exp_x      <= '0;
            exp_y      <= '0;
        end else if (idle_m && start) begin
            idle_m     <= 1'b0;
            cx_m       <= centre_x;
            cy_m       <= centre_y;
            d_m        <= diameter;
            colour_m   <= colour;
            plot_count <= 0;
            exp_x      <= '0;
            exp_y      <= '0;
        end else begin
            if (done && !start) begin
                idle_m <= 1'b1;
            end
            if (vga_plot) begin
                plot_count <= plot_count + 1;
                // y runs fastest
                if (exp_y == coord_y_t'(screen_h - 1)) begin
                    exp_y <= '0;
                    exp_x <= exp_x + 1'b1;
                end else begin
                    exp_y <= exp_y + 1'b1;
                end
            end
        end
    end

    // outline box around the triangle
    // integer vertex offsets let large outlines spread a few pixels past it
    always_comb begin
        slack = 2 + int'(d_m) / 64;
        top_y = int'(cy_m) - (int'(d_m) * int'(top_num)) / 1024;
        x_lo  = int'(cx_m) - int'(d_m) / 2 - slack;
        x_hi  = int'(cx_m) + int'(d_m) / 2 + slack;
        y_hi  = top_y + int'(d_m) + slack;
    end

    a_idle_quiet: assert property (@(posedge vif) disable iff (reset)
        idle_m |-> !done && !vga_plot)
    else begin
        error_count++;
        $error("Error done %h vga_plot %h expected 0 while idle", $sampled(done),
               $sampled(vga_plot));
    end

    a_clear_raster: assert property (@(posedge vif) disable iff (reset)
        vga_plot && plot_count < clear_plots |->
            vga_x == exp_x && vga_y == exp_y && vga_colour == '0)
    else begin
        error_count++;
        $error("Error vga_x %h vga_y %h vga_colour %h expected %h %h 0", $sampled(vga_x),
               $sampled(vga_y), $sampled(vga_colour), $sampled(exp_x), $sampled(exp_y));
    end

    a_trace_colour: assert property (@(posedge vif) disable iff (reset)
        vga_plot && plot_count >= clear_plots |-> vga_colour == colour_m)
    else begin
        error_count++;
        $error("Error vga_colour %h expected %h", $sampled(vga_colour), $sampled(colour_m));
    end

    a_trace_place: assert property (@(posedge vif) disable iff (reset)
        vga_plot && plot_count >= clear_plots |->
            int'(vga_x) < screen_w && int'(vga_y) < screen_h &&
            int'(vga_x) >= x_lo && int'(vga_x) <= x_hi &&
            int'(vga_y) >= top_y - slack && int'(vga_y) <= y_hi)
    else begin
        error_count++;
        $error("Error vga_x %h vga_y %h outside screen or outline box", $sampled(vga_x),
               $sampled(vga_y));
    end

    a_zero_quiet: assert property (@(posedge vif) disable iff (reset)
        d_m == '0 && plot_count >= clear_plots |-> !vga_plot)
    else begin
        error_count++;
        $error("Error vga_plot %h expected 0 for diameter 0", $sampled(vga_plot));
    end

    a_done_quiet: assert property (@(posedge vif) disable iff (reset)
        done |-> !vga_plot && plot_count >= clear_plots)
    else begin
        error_count++;
        $error("Error vga_plot %h plot count %h with done high", $sampled(vga_plot),
               $sampled(plot_count));
    end

    a_done_hold: assert property (@(posedge vif) disable iff (reset)
        done && start |=> done)
    else begin
        error_count++;
        $error("Error done %h expected 1 while start is high", $sampled(done));
    end

    a_done_fall: assert property (@(posedge vif) disable iff (reset)
        done && !start |=> !done)
    else begin
        error_count++;
        $error("Error done %h expected 0 after start fell", $sampled(done));
    end

endmodule

/* testbench/tb_clock.sv */
module tb_clock (
    output logic vif,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    initial begin
        vif = 1'b0;
        forever #4 vif = ~vif;
    end

    // reset held for 4 cycles, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge vif);
        @(negedge vif);
        reset = 1'b0;
    end

endmodule

/* testbench/tb_reuleaux.sv */
module tb_reuleaux import reuleaux_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_cases   = 11;
    localparam int max_diam    = 254;
    localparam int cycle_limit = num_cases * (19200 + 8 * max_diam * 3 + 100);

    logic        vif;
    logic        reset;
    logic        start;
    coord_x_t    centre_x;
    coord_y_t    centre_y;
    diam_t       diameter;
    colour_t     colour;
    logic        done;
    coord_x_t    vga_x;
    coord_y_t    vga_y;
    colour_t     vga_colour;
    logic        vga_plot;

    logic [15:0] lfsr_state = 16'd45;
    int          cycle_count = 0;
    int          timeout_errors = 0;

    tb_clock u_clock (
        .vif   (vif),
        .reset (reset)
    );

    reuleaux_top #(
        .screen_w (160),
        .screen_h (120)
    ) uut (
        .vif        (vif),
        .reset      (reset),
        .start      (start),
        .centre_x   (centre_x),
        .centre_y   (centre_y),
        .diameter   (diameter),
        .colour     (colour),
        .done       (done),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_plot   (vga_plot)
    );

    bind reuleaux_top reuleaux_checker u_checker (
        .vif        (vif),
        .reset      (reset),
        .start      (start),
        .centre_x   (centre_x),
        .centre_y   (centre_y),
        .diameter   (diameter),
        .colour     (colour),
        .done       (done),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_plot   (vga_plot)
    );

    // galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end else begin
            return s >> 1;
        end
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic report_and_finish();
        int total;
        total = uut.u_checker.error_count + timeout_errors;
        $display("errors: %0d assertion, %0d timeout", uut.u_checker.error_count,
                 timeout_errors);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // one full drawing cycle, start released a random 0 to 7 cycles after done
    task automatic draw_case(input int cx, input int cy, input int d, input int col);
        int hold;
        @(negedge vif);
        centre_x = coord_x_t'(cx);
        centre_y = coord_y_t'(cy);
        diameter = diam_t'(d);
        colour   = colour_t'(col);
        start    = 1'b1;
        while (!done) begin
            @(negedge vif);
        end
        take_bits(3, hold);
        repeat (hold) @(negedge vif);
        start = 1'b0;
        repeat (2) @(negedge vif);
    endtask

    always @(posedge vif) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= cycle_limit);
        timeout_errors = timeout_errors + 1;
        $display("timeout: the drawing sequence did not finish within %0d cycles", cycle_limit);
        report_and_finish();
    end

    initial begin
        int rx;
        int ry;
        int rd;
        int rc;
        start    = 1'b0;
        centre_x = '0;
        centre_y = '0;
        diameter = '0;
        colour   = '0;
        @(negedge vif);
        while (reset) begin
            @(negedge vif);
        end
        // idle for a while so the quiet state after reset is seen
        repeat (5) @(negedge vif);
        draw_case(80, 60, 80, 2);
        // zero diameter
        draw_case(80, 60, 0, 5);
        draw_case(0, 0, 0, 7);
        draw_case(159, 119, 0, 1);
        // centres in the corners
        draw_case(0, 0, 60, 3);
        draw_case(159, 0, 120, 4);
        draw_case(159, 119, 254, 6);
        for (int i = 0; i < 4; i++) begin
            take_bits(8, rx);
            take_bits(7, ry);
            take_bits(8, rd);
            take_bits(3, rc);
            draw_case(rx % 160, ry % 120, rd & 32'hFE, rc);
        end
        report_and_finish();
    end

endmodule

/* reuleaux_top.f */
verilog/reuleaux_pkg.sv
verilog/pixel_if.sv
verilog/screen_clear.sv
verilog/arc_tracer.sv
verilog/arc_clip.sv
verilog/draw_control.sv
verilog/reuleaux_top.sv
testbench/reuleaux_properties.sv
testbench/tb_clock.sv
testbench/tb_reuleaux.sv

/* run_sim.sh */
#!/bin/sh
# build and run the reuleaux testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_reuleaux -f reuleaux_top.f --Mdir obj_dir -o sim_reuleaux

# the log decides the result, not the exit status of the run
./obj_dir/sim_reuleaux +verilator+error+limit+1000000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1
